// ==== rtl/cl_ddr_stat_cfg.svh ====
//////////////////////////////////////////////////
// DDR statistics wrapper configuration
// Channel count, pipeline depths, reset staging
// and field widths of the statistics port
//////////////////////////////////////////////////

`ifndef CL_DDR_STAT_CFG_SVH
`define CL_DDR_STAT_CFG_SVH

// Number of DDR statistics channels
`define CL_STAT_NUM_CHAN 3

// Register depth of each direction of a statistics pipeline
`define CL_STAT_PIPE_STAGES 8

// Flops from pipe_rst_n to sync_rst_n
`define CL_SYNC_RST_STAGES 2

// Further flops from sync_rst_n to the DDR controller reset
`define CL_DDR_RST_STAGES 4

//////////////////////////////////////////////////
// Statistics field widths
//////////////////////////////////////////////////
`define CL_STAT_ADDR_W 8
`define CL_STAT_DATA_W 32
`define CL_STAT_INT_W 8

`endif

// ==== rtl/cl_ddr_stat_pkg.sv ====
//////////////////////////////////////////////////
// DDR statistics types
// Vector types for the address, data and
// interrupt fields of the statistics channels
//////////////////////////////////////////////////

`include "cl_ddr_stat_cfg.svh"

package cl_ddr_stat_pkg;

   //////////////////////////////////////////////////
   // Statistics port fields
   //////////////////////////////////////////////////

   // Statistics register address, one word
   typedef logic [`CL_STAT_ADDR_W-1:0] stat_addr_t;

   // Write data toward the controller, read data back
   typedef logic [`CL_STAT_DATA_W-1:0] stat_data_t;

   // Interrupt status bits returned with each ack
   typedef logic [`CL_STAT_INT_W-1:0] stat_int_t;

endpackage

// ==== rtl/reset_ctrl.sv ====
//////////////////////////////////////////////////
// Reset control
// Stages the piped main reset into sync_rst_n,
// stages a later reset for the DDR controller,
// and answers an FLR assert with a done pulse
//////////////////////////////////////////////////

`include "cl_ddr_stat_cfg.svh"

module reset_ctrl
(
   input  logic clk,
   input  logic pipe_rst_n,
   input  logic sh_cl_flr_assert,
   output logic sync_rst_n,
   output logic ddr_rst_n,
   output logic cl_sh_flr_done
);

   localparam int SYNC_STAGES = `CL_SYNC_RST_STAGES;
   localparam int DDR_STAGES  = `CL_DDR_RST_STAGES;

   logic [SYNC_STAGES-1:0] sync_chain;
   logic [DDR_STAGES-1:0]  ddr_chain;
   logic                   flr_assert_q;

   //////////////////////////////////////////////////
   // Main reset staging
   //////////////////////////////////////////////////

   // A one is shifted in once pipe_rst_n is seen high
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         sync_chain <= '0;
      end
      else
      begin
         sync_chain[0] <= 1'b1;
         for (int i = 1; i < SYNC_STAGES; i++)
         begin
            sync_chain[i] <= sync_chain[i-1];
         end
      end
   end

   assign sync_rst_n = sync_chain[SYNC_STAGES-1];

   //////////////////////////////////////////////////
   // DDR controller reset staging
   //////////////////////////////////////////////////

   // Follows sync_rst_n, cleared at once by pipe_rst_n
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         ddr_chain <= '0;
      end
      else
      begin
         ddr_chain[0] <= sync_rst_n;
         for (int i = 1; i < DDR_STAGES; i++)
         begin
            ddr_chain[i] <= ddr_chain[i-1];
         end
      end
   end

   assign ddr_rst_n = ddr_chain[DDR_STAGES-1];

   //////////////////////////////////////////////////
   // FLR response
   //////////////////////////////////////////////////

   // Done toggles while the registered assert is held,
   // so the shell sees a pulse every other cycle
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

endmodule

// ==== rtl/ddr_stat_pipe.sv ====
//////////////////////////////////////////////////
// DDR statistics channel pipeline
// Fixed-depth register stages on the request path
// toward the controller and on the ack path back
// to the shell, for timing across the die
//////////////////////////////////////////////////

`include "cl_ddr_stat_cfg.svh"

module ddr_stat_pipe
   import cl_ddr_stat_pkg::*;
#(
   parameter int STAGES = `CL_STAT_PIPE_STAGES
)
(
   input  logic       clk,
   input  logic       sync_rst_n,
   // Request from the shell
   input  logic       sh_wr,
   input  logic       sh_rd,
   input  stat_addr_t sh_addr,
   input  stat_data_t sh_wdata,
   // Acknowledge from the controller
   input  logic       ctl_ack,
   input  stat_data_t ctl_rdata,
   input  stat_int_t  ctl_int,
   // Request toward the controller
   output logic       ctl_wr,
   output logic       ctl_rd,
   output stat_addr_t ctl_addr,
   output stat_data_t ctl_wdata,
   // Acknowledge toward the shell
   output logic       sh_ack,
   output stat_data_t sh_rdata,
   output stat_int_t  sh_int
);

   localparam int REQ_W = 2 + $bits(stat_addr_t) + $bits(stat_data_t);
   localparam int ACK_W = 1 + $bits(stat_int_t) + $bits(stat_data_t);

   logic [REQ_W-1:0] req_in;
   logic [ACK_W-1:0] ack_in;
   logic [REQ_W-1:0] req_pipe [STAGES];
   logic [ACK_W-1:0] ack_pipe [STAGES];

   // Each direction travels as one flat bundle
   assign req_in = {sh_wr, sh_rd, sh_addr, sh_wdata};
   assign ack_in = {ctl_ack, ctl_int, ctl_rdata};

   //////////////////////////////////////////////////
   // Request path
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            req_pipe[i] <= '0;
         end
      end
      else
      begin
         req_pipe[0] <= req_in;
         for (int i = 1; i < STAGES; i++)
         begin
            req_pipe[i] <= req_pipe[i-1];
         end
      end
   end

   assign {ctl_wr, ctl_rd, ctl_addr, ctl_wdata} = req_pipe[STAGES-1];

   //////////////////////////////////////////////////
   // Acknowledge path
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            ack_pipe[i] <= '0;
         end
      end
      else
      begin
         ack_pipe[0] <= ack_in;
         for (int i = 1; i < STAGES; i++)
         begin
            ack_pipe[i] <= ack_pipe[i-1];
         end
      end
   end

   assign {sh_ack, sh_int, sh_rdata} = ack_pipe[STAGES-1];

endmodule

// ==== rtl/cl_ddr_stat_top.sv ====
//////////////////////////////////////////////////
// Custom logic DDR statistics wrapper
// Reset staging, FLR response and the three
// pipelined statistics channels between the
// shell and the external DDR controller
//////////////////////////////////////////////////

`include "cl_ddr_stat_cfg.svh"

module cl_ddr_stat_top
   import cl_ddr_stat_pkg::*;
(
   input  logic       clk_main_a0,
   input  logic       pipe_rst_n,
   input  logic       sh_cl_flr_assert,
   output logic       cl_sh_flr_done,
   output logic       ddr_rst_n,

   // Channel 0
   input  logic       sh_ddr_stat_wr0,
   input  logic       sh_ddr_stat_rd0,
   input  stat_addr_t sh_ddr_stat_addr0,
   input  stat_data_t sh_ddr_stat_wdata0,
   input  logic       ctl_stat_ack0,
   input  stat_data_t ctl_stat_rdata0,
   input  stat_int_t  ctl_stat_int0,
   output logic       ddr_sh_stat_ack0,
   output stat_data_t ddr_sh_stat_rdata0,
   output stat_int_t  ddr_sh_stat_int0,
   output logic       ctl_stat_wr0,
   output logic       ctl_stat_rd0,
   output stat_addr_t ctl_stat_addr0,
   output stat_data_t ctl_stat_wdata0,

   // Channel 1
   input  logic       sh_ddr_stat_wr1,
   input  logic       sh_ddr_stat_rd1,
   input  stat_addr_t sh_ddr_stat_addr1,
   input  stat_data_t sh_ddr_stat_wdata1,
   input  logic       ctl_stat_ack1,
   input  stat_data_t ctl_stat_rdata1,
   input  stat_int_t  ctl_stat_int1,
   output logic       ddr_sh_stat_ack1,
   output stat_data_t ddr_sh_stat_rdata1,
   output stat_int_t  ddr_sh_stat_int1,
   output logic       ctl_stat_wr1,
   output logic       ctl_stat_rd1,
   output stat_addr_t ctl_stat_addr1,
   output stat_data_t ctl_stat_wdata1,

   // Channel 2
   input  logic       sh_ddr_stat_wr2,
   input  logic       sh_ddr_stat_rd2,
   input  stat_addr_t sh_ddr_stat_addr2,
   input  stat_data_t sh_ddr_stat_wdata2,
   input  logic       ctl_stat_ack2,
   input  stat_data_t ctl_stat_rdata2,
   input  stat_int_t  ctl_stat_int2,
   output logic       ddr_sh_stat_ack2,
   output stat_data_t ddr_sh_stat_rdata2,
   output stat_int_t  ddr_sh_stat_int2,
   output logic       ctl_stat_wr2,
   output logic       ctl_stat_rd2,
   output stat_addr_t ctl_stat_addr2,
   output stat_data_t ctl_stat_wdata2
);

   // Same depth on every channel so they stay aligned
   localparam int STAT_STAGES = `CL_STAT_PIPE_STAGES;

   logic sync_rst_n;

   //////////////////////////////////////////////////
   // Reset tree and FLR
   //////////////////////////////////////////////////

   reset_ctrl u_reset_ctrl (
      .clk              (clk_main_a0),
      .pipe_rst_n       (pipe_rst_n),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .sync_rst_n       (sync_rst_n),
      .ddr_rst_n        (ddr_rst_n),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   //////////////////////////////////////////////////
   // Statistics channels
   //////////////////////////////////////////////////

   ddr_stat_pipe #(.STAGES(STAT_STAGES)) u_stat_pipe0 (
      .clk        (clk_main_a0),
      .sync_rst_n (sync_rst_n),
      .sh_wr      (sh_ddr_stat_wr0),
      .sh_rd      (sh_ddr_stat_rd0),
      .sh_addr    (sh_ddr_stat_addr0),
      .sh_wdata   (sh_ddr_stat_wdata0),
      .ctl_ack    (ctl_stat_ack0),
      .ctl_rdata  (ctl_stat_rdata0),
      .ctl_int    (ctl_stat_int0),
      .ctl_wr     (ctl_stat_wr0),
      .ctl_rd     (ctl_stat_rd0),
      .ctl_addr   (ctl_stat_addr0),
      .ctl_wdata  (ctl_stat_wdata0),
      .sh_ack     (ddr_sh_stat_ack0),
      .sh_rdata   (ddr_sh_stat_rdata0),
      .sh_int     (ddr_sh_stat_int0)
   );

   ddr_stat_pipe #(.STAGES(STAT_STAGES)) u_stat_pipe1 (
      .clk        (clk_main_a0),
      .sync_rst_n (sync_rst_n),
      .sh_wr      (sh_ddr_stat_wr1),
      .sh_rd      (sh_ddr_stat_rd1),
      .sh_addr    (sh_ddr_stat_addr1),
      .sh_wdata   (sh_ddr_stat_wdata1),
      .ctl_ack    (ctl_stat_ack1),
      .ctl_rdata  (ctl_stat_rdata1),
      .ctl_int    (ctl_stat_int1),
      .ctl_wr     (ctl_stat_wr1),
      .ctl_rd     (ctl_stat_rd1),
      .ctl_addr   (ctl_stat_addr1),
      .ctl_wdata  (ctl_stat_wdata1),
      .sh_ack     (ddr_sh_stat_ack1),
      .sh_rdata   (ddr_sh_stat_rdata1),
      .sh_int     (ddr_sh_stat_int1)
   );

   ddr_stat_pipe #(.STAGES(STAT_STAGES)) u_stat_pipe2 (
      .clk        (clk_main_a0),
      .sync_rst_n (sync_rst_n),
      .sh_wr      (sh_ddr_stat_wr2),
      .sh_rd      (sh_ddr_stat_rd2),
      .sh_addr    (sh_ddr_stat_addr2),
      .sh_wdata   (sh_ddr_stat_wdata2),
      .ctl_ack    (ctl_stat_ack2),
      .ctl_rdata  (ctl_stat_rdata2),
      .ctl_int    (ctl_stat_int2),
      .ctl_wr     (ctl_stat_wr2),
      .ctl_rd     (ctl_stat_rd2),
      .ctl_addr   (ctl_stat_addr2),
      .ctl_wdata  (ctl_stat_wdata2),
      .sh_ack     (ddr_sh_stat_ack2),
      .sh_rdata   (ddr_sh_stat_rdata2),
      .sh_int     (ddr_sh_stat_int2)
   );

endmodule

// ==== verif/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock generator
// Free-running clock, period 10
//////////////////////////////////////////////////

module tb_clk_gen
#(
   parameter int PERIOD = 10
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
   end

   always #(PERIOD/2) clk = ~clk;

endmodule

// ==== verif/tb_cl_ddr_stat.sv ====
//////////////////////////////////////////////////
// DDR statistics wrapper testbench
// Drives the shell side, models the controller,
// and compares every output each cycle against
// a reference built from input history
//////////////////////////////////////////////////

`include "cl_ddr_stat_cfg.svh"

module tb_cl_ddr_stat
   import cl_ddr_stat_pkg::*;
();

   localparam int NCH     = `CL_STAT_NUM_CHAN;
   localparam int S       = `CL_STAT_PIPE_STAGES;
   localparam int SYNC_ST = `CL_SYNC_RST_STAGES;
   localparam int DDR_ST  = `CL_DDR_RST_STAGES;
   localparam int DW      = $bits(stat_data_t);
   localparam int AW      = $bits(stat_addr_t);
   localparam int IW      = $bits(stat_int_t);
   localparam int REQ_W   = 2 + AW + DW;
   localparam int ACK_W   = 1 + IW + DW;
   localparam int REQ_PER_CH = 30;
   localparam int MAX_CYC = 8192;

   logic clk_main_a0;
   logic pipe_rst_n;
   logic sh_cl_flr_assert;
   logic cl_sh_flr_done;
   logic ddr_rst_n;

   // Shell and controller side inputs per channel
   logic       sh_wr [NCH];
   logic       sh_rd [NCH];
   stat_addr_t sh_addr [NCH];
   stat_data_t sh_wdata [NCH];
   logic       ctl_ack [NCH];
   stat_data_t ctl_rdata [NCH];
   stat_int_t  ctl_int [NCH];
   // DUT outputs
   logic       sh_ack_o [NCH];
   stat_data_t sh_rdata_o [NCH];
   stat_int_t  sh_int_o [NCH];
   logic       ctl_wr_o [NCH];
   logic       ctl_rd_o [NCH];
   stat_addr_t ctl_addr_o [NCH];
   stat_data_t ctl_wdata_o [NCH];

   // Input history per rising edge
   logic [REQ_W-1:0] req_hist [NCH][MAX_CYC];
   logic [ACK_W-1:0] ack_hist [NCH][MAX_CYC];
   logic             prst_hist [MAX_CYC];
   logic             fa_hist [MAX_CYC];
   int               edge_cnt = 0;

   // Controller model state
   stat_data_t model_mem [NCH][256];
   stat_data_t shadow [NCH][256];
   bit         pend [NCH];
   int         pend_cnt [NCH];
   stat_data_t resp_data [NCH];
   stat_int_t  resp_int [NCH];
   bit         model_en;

   integer seed;
   int     checks = 0;
   int     errors = 0;
   int     cmp_c;
   logic   done_exp = 1'b0;
   logic [REQ_W-1:0] exp_req;
   logic [ACK_W-1:0] exp_ack;

   tb_clk_gen #(.PERIOD(10)) u_clk_gen (.clk(clk_main_a0));

   cl_ddr_stat_top uut (
      .clk_main_a0        (clk_main_a0),
      .pipe_rst_n         (pipe_rst_n),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .ddr_rst_n          (ddr_rst_n),
      .sh_ddr_stat_wr0    (sh_wr[0]),
      .sh_ddr_stat_rd0    (sh_rd[0]),
      .sh_ddr_stat_addr0  (sh_addr[0]),
      .sh_ddr_stat_wdata0 (sh_wdata[0]),
      .ctl_stat_ack0      (ctl_ack[0]),
      .ctl_stat_rdata0    (ctl_rdata[0]),
      .ctl_stat_int0      (ctl_int[0]),
      .ddr_sh_stat_ack0   (sh_ack_o[0]),
      .ddr_sh_stat_rdata0 (sh_rdata_o[0]),
      .ddr_sh_stat_int0   (sh_int_o[0]),
      .ctl_stat_wr0       (ctl_wr_o[0]),
      .ctl_stat_rd0       (ctl_rd_o[0]),
      .ctl_stat_addr0     (ctl_addr_o[0]),
      .ctl_stat_wdata0    (ctl_wdata_o[0]),
      .sh_ddr_stat_wr1    (sh_wr[1]),
      .sh_ddr_stat_rd1    (sh_rd[1]),
      .sh_ddr_stat_addr1  (sh_addr[1]),
      .sh_ddr_stat_wdata1 (sh_wdata[1]),
      .ctl_stat_ack1      (ctl_ack[1]),
      .ctl_stat_rdata1    (ctl_rdata[1]),
      .ctl_stat_int1      (ctl_int[1]),
      .ddr_sh_stat_ack1   (sh_ack_o[1]),
      .ddr_sh_stat_rdata1 (sh_rdata_o[1]),
      .ddr_sh_stat_int1   (sh_int_o[1]),
      .ctl_stat_wr1       (ctl_wr_o[1]),
      .ctl_stat_rd1       (ctl_rd_o[1]),
      .ctl_stat_addr1     (ctl_addr_o[1]),
      .ctl_stat_wdata1    (ctl_wdata_o[1]),
      .sh_ddr_stat_wr2    (sh_wr[2]),
      .sh_ddr_stat_rd2    (sh_rd[2]),
      .sh_ddr_stat_addr2  (sh_addr[2]),
      .sh_ddr_stat_wdata2 (sh_wdata[2]),
      .ctl_stat_ack2      (ctl_ack[2]),
      .ctl_stat_rdata2    (ctl_rdata[2]),
      .ctl_stat_int2      (ctl_int[2]),
      .ddr_sh_stat_ack2   (sh_ack_o[2]),
      .ddr_sh_stat_rdata2 (sh_rdata_o[2]),
      .ddr_sh_stat_int2   (sh_int_o[2]),
      .ctl_stat_wr2       (ctl_wr_o[2]),
      .ctl_stat_rd2       (ctl_rd_o[2]),
      .ctl_stat_addr2     (ctl_addr_o[2]),
      .ctl_stat_wdata2    (ctl_wdata_o[2])
   );

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic bit prst_at(int e);
      return (e >= 0) ? (prst_hist[e] === 1'b1) : 1'b0;
   endfunction

   // sync_rst_n as seen by the flops at edge e
   function automatic bit sync_before(int e);
      for (int k = 1; k <= SYNC_ST; k++)
      begin
         if (!prst_at(e - k))
            return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic bit ref_ddr_rst(int c);
      for (int k = 0; k < SYNC_ST + DDR_ST; k++)
      begin
         if (!prst_at(c - k))
            return 1'b0;
      end
      return 1'b1;
   endfunction

   // Pipeline output after edge c is the input of edge c-S+1 unless a reset hit it
   function automatic bit pipe_open(int c);
      if (c - S + 1 < 0)
         return 1'b0;
      for (int e = c - S + 1; e <= c; e++)
      begin
         if (!sync_before(e))
            return 1'b0;
      end
      return 1'b1;
   endfunction

   function automatic logic ref_flr_done(int c, logic prev);
      logic flr_q;
      flr_q = (c >= 1) && sync_before(c - 1) && (fa_hist[c-1] === 1'b1);
      return sync_before(c) && flr_q && !prev;
   endfunction

   // Per-channel constant mixed into read data
   function automatic stat_data_t chan_key(int ch);
      case (ch)
         0:       return 32'h1357_9bdf;
         1:       return 32'h2468_ace0;
         default: return 32'h0f0f_a5c3;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Inputs are stable at the edge, so they are recorded there
   always @(posedge clk_main_a0)
   begin
      prst_hist[edge_cnt] = pipe_rst_n;
      fa_hist[edge_cnt]   = sh_cl_flr_assert;
      for (int ch = 0; ch < NCH; ch++)
      begin
         req_hist[ch][edge_cnt] = {sh_wr[ch], sh_rd[ch], sh_addr[ch], sh_wdata[ch]};
         ack_hist[ch][edge_cnt] = {ctl_ack[ch], ctl_int[ch], ctl_rdata[ch]};
      end
      edge_cnt++;
   end

   //////////////////////////////////////////////////
   // Compare process at the falling edge
   //////////////////////////////////////////////////

   always @(negedge clk_main_a0)
   begin
      if (edge_cnt > 0)
      begin
         cmp_c    = edge_cnt - 1;
         done_exp = ref_flr_done(cmp_c, done_exp);
         // Outputs are defined once the first reset edge has passed
         if (cmp_c >= 1)
         begin
            check_val("ddr_rst_n", ddr_rst_n, ref_ddr_rst(cmp_c));
            check_val("cl_sh_flr_done", cl_sh_flr_done, done_exp);
            for (int ch = 0; ch < NCH; ch++)
            begin
               exp_req = pipe_open(cmp_c) ? req_hist[ch][cmp_c-S+1] : '0;
               exp_ack = pipe_open(cmp_c) ? ack_hist[ch][cmp_c-S+1] : '0;
               check_val($sformatf("ctl_stat_wr%0d", ch), ctl_wr_o[ch], exp_req[REQ_W-1]);
               check_val($sformatf("ctl_stat_rd%0d", ch), ctl_rd_o[ch], exp_req[REQ_W-2]);
               check_val($sformatf("ctl_stat_addr%0d", ch), ctl_addr_o[ch], exp_req[DW +: AW]);
               check_val($sformatf("ctl_stat_wdata%0d", ch), ctl_wdata_o[ch], exp_req[DW-1:0]);
               check_val($sformatf("ddr_sh_stat_ack%0d", ch), sh_ack_o[ch], exp_ack[ACK_W-1]);
               check_val($sformatf("ddr_sh_stat_int%0d", ch), sh_int_o[ch], exp_ack[DW +: IW]);
               check_val($sformatf("ddr_sh_stat_rdata%0d", ch), sh_rdata_o[ch], exp_ack[DW-1:0]);
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // DDR controller model
   //////////////////////////////////////////////////

   // Acks each request after 0 to 3 cycles
   always @(posedge clk_main_a0)
   begin
      #1;
      for (int ch = 0; ch < NCH; ch++)
      begin
         if (!pipe_rst_n)
            pend[ch] = 1'b0;
         if (model_en)
         begin
            if (pipe_rst_n && (ctl_wr_o[ch] || ctl_rd_o[ch]))
            begin
               if (ctl_wr_o[ch])
                  model_mem[ch][ctl_addr_o[ch]] = ctl_wdata_o[ch];
               resp_data[ch] = ctl_rd_o[ch] ?
                  (stat_data_t'(ctl_addr_o[ch]) ^ chan_key(ch) ^ model_mem[ch][ctl_addr_o[ch]]) :
                  '0;
               resp_int[ch] = $random(seed);
               pend_cnt[ch] = $unsigned($random(seed)) % 4;
               pend[ch]     = 1'b1;
            end
            ctl_ack[ch]   = 1'b0;
            ctl_rdata[ch] = '0;
            ctl_int[ch]   = '0;
            if (pend[ch] && pend_cnt[ch] == 0)
            begin
               ctl_ack[ch]   = 1'b1;
               ctl_rdata[ch] = resp_data[ch];
               ctl_int[ch]   = resp_int[ch];
               pend[ch]      = 1'b0;
            end
            else if (pend[ch])
               pend_cnt[ch]--;
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   // Random writes and reads on one channel with one request outstanding
   task automatic run_channel(input int ch, input int n);
      bit         is_wr;
      stat_addr_t addr;
      stat_data_t data;
      stat_data_t exp;
      for (int k = 0; k < n; k++)
      begin
         is_wr = $random(seed);
         addr  = $unsigned($random(seed)) % 4;
         data  = $random(seed);
         @(posedge clk_main_a0);
         #1;
         sh_wr[ch]    = is_wr;
         sh_rd[ch]    = !is_wr;
         sh_addr[ch]  = addr;
         sh_wdata[ch] = data;
         @(posedge clk_main_a0);
         #1;
         sh_wr[ch] = 1'b0;
         sh_rd[ch] = 1'b0;
         do
            @(negedge clk_main_a0);
         while (sh_ack_o[ch] !== 1'b1);
         if (is_wr)
            shadow[ch][addr] = data;
         else
         begin
            exp = stat_data_t'(addr) ^ chan_key(ch) ^ shadow[ch][addr];
            checks++;
            if (sh_rdata_o[ch] !== exp)
            begin
               errors++;
               $display("FAILED t=%0t ddr_sh_stat_rdata%0d got %h expected %h",
                        $time, ch, sh_rdata_o[ch], exp);
            end
         end
      end
   endtask

   initial
   begin
      seed             = 32'h27e4_1e05;
      model_en         = 1'b1;
      pipe_rst_n       = 1'b0;
      sh_cl_flr_assert = 1'b0;
      for (int ch = 0; ch < NCH; ch++)
      begin
         sh_wr[ch]     = 1'b0;
         sh_rd[ch]     = 1'b0;
         sh_addr[ch]   = '0;
         sh_wdata[ch]  = '0;
         ctl_ack[ch]   = 1'b0;
         ctl_rdata[ch] = '0;
         ctl_int[ch]   = '0;
         pend[ch]      = 1'b0;
         for (int a = 0; a < 256; a++)
         begin
            model_mem[ch][a] = '0;
            shadow[ch][a]    = '0;
         end
      end
      repeat (5) @(posedge clk_main_a0);
      #1 pipe_rst_n = 1'b1;
      repeat (10) @(posedge clk_main_a0);

      // All channels at once
      fork
         run_channel(0, REQ_PER_CH);
         run_channel(1, REQ_PER_CH);
         run_channel(2, REQ_PER_CH);
      join

      // Held FLR assert and its release
      @(posedge clk_main_a0);
      #1 sh_cl_flr_assert = 1'b1;
      repeat (12) @(posedge clk_main_a0);
      #1 sh_cl_flr_assert = 1'b0;
      repeat (6) @(posedge clk_main_a0);

      // Back-to-back items on every channel with the model idle
      model_en = 1'b0;
      for (int k = 0; k < S; k++)
      begin
         @(posedge clk_main_a0);
         #1;
         for (int ch = 0; ch < NCH; ch++)
         begin
            ctl_ack[ch]   = 1'b1;
            ctl_rdata[ch] = $random(seed);
            ctl_int[ch]   = k * 16 + ch;
            sh_wr[ch]     = 1'b1;
            sh_addr[ch]   = $random(seed);
            sh_wdata[ch]  = $random(seed);
         end
      end
      @(posedge clk_main_a0);
      #1;
      for (int ch = 0; ch < NCH; ch++)
      begin
         ctl_ack[ch] = 1'b0;
         sh_wr[ch]   = 1'b0;
      end
      repeat (12) @(posedge clk_main_a0);
      model_en = 1'b1;

      // Reset while requests and acks are in flight
      for (int k = 0; k < 10; k++)
      begin
         @(posedge clk_main_a0);
         #1;
         for (int ch = 0; ch < NCH; ch++)
         begin
            sh_wr[ch]    = (k % 4 == 0);
            sh_rd[ch]    = (k % 4 == 2);
            sh_addr[ch]  = k;
            sh_wdata[ch] = $random(seed);
         end
      end
      @(posedge clk_main_a0);
      #1;
      pipe_rst_n = 1'b0;
      for (int ch = 0; ch < NCH; ch++)
      begin
         sh_wr[ch] = 1'b0;
         sh_rd[ch] = 1'b0;
      end
      repeat (5) @(posedge clk_main_a0);
      #1 pipe_rst_n = 1'b1;
      repeat (30) @(posedge clk_main_a0);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Watchdog sized from the request count
   initial
   begin
      repeat (2000 + 40 * NCH * REQ_PER_CH) @(posedge clk_main_a0);
      $display("Timeout: the run did not finish, checks %0d, errors %0d", checks, errors);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/cl_ddr_stat_pkg.sv
rtl/reset_ctrl.sv
rtl/ddr_stat_pipe.sv
rtl/cl_ddr_stat_top.sv
verif/tb_clk_gen.sv
verif/tb_cl_ddr_stat.sv

// ==== Bender.yml ====
package:
  name: cl_ddr_stat

sources:
  # Design sources
  - include_dirs:
      - rtl
    files:
      - rtl/cl_ddr_stat_pkg.sv
      - rtl/reset_ctrl.sv
      - rtl/ddr_stat_pipe.sv
      - rtl/cl_ddr_stat_top.sv

  # Testbench sources
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_cl_ddr_stat.sv
